// ==== Bender.yml ====
package:
  name: pmem

export_include_dirs:
  - .

sources:
  - files:
      - pmem_geom_pkg.sv
      - pmem_csr_pkg.sv
      - pmem_map_table.sv
      - pmem_remap_stage.sv
      - pmem_bank_array.sv
      - pmem_csr.sv
      - pmem_core.sv
  - target: test
    files:
      - pmem_props.sv
      - tb_pmem.sv

// ==== pmem_bank_array.sv ====
`timescale 1ns/1ps

`include "pmem_cfg.svh"

module pmem_bank_array (
  input  logic                  clk,
  input  logic                  rst_sync,
  input  logic                  rd_en,
  input  pmem_geom_pkg::pbank_t rd_bank,
  input  pmem_geom_pkg::row_t   rd_row,
  input  logic                  wr_en,
  input  pmem_geom_pkg::pbank_t wr_bank,
  input  pmem_geom_pkg::row_t   wr_row,
  input  pmem_geom_pkg::data_t  wr_data,
  output logic                  vread_vld,  // one cycle after rd_en.
  output pmem_geom_pkg::data_t  vdout
);

  pmem_geom_pkg::data_t  bank_dout [`PMEM_NUM_PBNK];  // output register of every bank.
  pmem_geom_pkg::pbank_t rd_bank_q;  // bank whose output register holds the read.

  for (genvar b = 0; b < `PMEM_NUM_PBNK; b++) begin : g_bank
    pmem_geom_pkg::data_t mem [`PMEM_NUM_VROW];
    pmem_geom_pkg::data_t dout_q;
    logic                 sel_rd;
    logic                 sel_wr;

    assign sel_rd = rd_en && (rd_bank == b);
    assign sel_wr = wr_en && (wr_bank == b);

    // single port, so a bank does either one write or one read per cycle.
    always_ff @(posedge clk) begin
      if (sel_wr) begin
        mem[wr_row] <= wr_data;
      end else if (sel_rd) begin
        dout_q <= mem[rd_row];
      end
    end

    assign bank_dout[b] = dout_q;
  end

  always_ff @(posedge clk) begin
    if (rst_sync) begin
      vread_vld <= 1'b0;
    end else begin
      vread_vld <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_bank_q <= rd_bank;
    end
  end

  assign vdout = bank_dout[rd_bank_q];  // picks the bank that was read last cycle.

endmodule

// ==== pmem_cfg.svh ====
`ifndef PMEM_CFG_SVH
`define PMEM_CFG_SVH

// data word width in bits.
`define PMEM_WIDTH 16

`define PMEM_NUM_VBNK 4   // virtual banks seen by the address.
`define PMEM_BIT_VBNK 2   // low address bits that pick the virtual bank.
`define PMEM_NUM_PBNK 5   // physical banks, one more than virtual for the pivot.
`define PMEM_BIT_PBNK 3   // bits to name a physical bank.
`define PMEM_NUM_VROW 16  // rows per bank, one map row each.
`define PMEM_BIT_VROW 4   // high address bits that pick the row.
`define PMEM_BIT_VADDR 6  // full virtual address width.

// APB register map, byte offsets.
`define PMEM_APB_AW         5
`define PMEM_REG_CTRL       5'h00
`define PMEM_REG_STATUS     5'h04
`define PMEM_REG_REMAP_CNT  5'h08
`define PMEM_REG_MAP_QUERY  5'h0C
`define PMEM_REG_MAP_RESULT 5'h10

`endif

// ==== pmem_core.sv ====
`timescale 1ns/1ps

module pmem_core (
  input  logic                    clk,
  input  logic                    rst_sync,
  input  logic                    vread,
  input  pmem_geom_pkg::vaddr_t   vread_addr,
  output logic                    vread_vld,
  output pmem_geom_pkg::data_t    vdout,
  input  logic                    vwrite,
  input  pmem_geom_pkg::vaddr_t   vwrite_addr,
  input  pmem_geom_pkg::data_t    vwrite_data,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  pmem_csr_pkg::apb_addr_t paddr,
  input  pmem_csr_pkg::apb_data_t pwdata,
  output pmem_csr_pkg::apb_data_t prdata,
  output logic                    pready,
  output logic                    pslverr
);

  logic                    accept_en;
  logic                    init_done;
  logic                    remap_hit;
  pmem_geom_pkg::row_t     q_row;
  pmem_geom_pkg::vbank_t   q_vbank;
  pmem_geom_pkg::pbank_t   q_pbank;
  pmem_geom_pkg::row_t     lk_rd_row;
  pmem_geom_pkg::row_t     lk_wr_row;
  pmem_geom_pkg::map_row_t lk_rd_map;
  pmem_geom_pkg::map_row_t lk_wr_map;
  logic                    upd_en;
  pmem_geom_pkg::row_t     upd_row;
  pmem_geom_pkg::map_row_t upd_map;
  logic                    rd_en;
  pmem_geom_pkg::pbank_t   rd_bank;
  pmem_geom_pkg::row_t     rd_row;
  logic                    wr_en;
  pmem_geom_pkg::pbank_t   wr_bank;
  pmem_geom_pkg::row_t     wr_row;
  pmem_geom_pkg::data_t    wr_data;

  pmem_csr u_csr (
    .clk, .rst_sync, .psel, .penable, .pwrite, .paddr, .pwdata,
    .init_done, .remap_hit, .q_pbank,
    .prdata, .pready, .pslverr, .accept_en, .q_row, .q_vbank
  );

  pmem_map_table u_map_table (
    .clk, .rst_sync, .lk_rd_row, .lk_wr_row, .upd_en, .upd_row, .upd_map,
    .q_row, .q_vbank,
    .lk_rd_map, .lk_wr_map, .q_pbank, .init_done
  );

  pmem_remap_stage u_remap_stage (
    .clk, .rst_sync, .accept_en,
    .vread, .vread_addr, .vwrite, .vwrite_addr, .vwrite_data,
    .lk_rd_map, .lk_wr_map, .lk_rd_row, .lk_wr_row,
    .rd_en, .rd_bank, .rd_row, .wr_en, .wr_bank, .wr_row, .wr_data,
    .upd_en, .upd_row, .upd_map, .remap_hit
  );

  pmem_bank_array u_bank_array (
    .clk, .rst_sync,
    .rd_en, .rd_bank, .rd_row, .wr_en, .wr_bank, .wr_row, .wr_data,
    .vread_vld, .vdout
  );

endmodule

// ==== pmem_csr.sv ====
`timescale 1ns/1ps

`include "pmem_cfg.svh"

module pmem_csr (
  input  logic                     clk,
  input  logic                     rst_sync,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  pmem_csr_pkg::apb_addr_t  paddr,
  input  pmem_csr_pkg::apb_data_t  pwdata,
  input  logic                     init_done,  // map sweep finished.
  input  logic                     remap_hit,
  input  pmem_geom_pkg::pbank_t    q_pbank,    // answer of the map query.
  output pmem_csr_pkg::apb_data_t  prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     accept_en,
  output pmem_geom_pkg::row_t      q_row,
  output pmem_geom_pkg::vbank_t    q_vbank
);

  logic                     apb_acc;    // access phase, the transfer completes now.
  logic                     apb_wr;
  logic                     addr_ok;    // offset is in the register map.
  logic                     addr_ro;    // offset is read only.
  logic                     enable_q;
  pmem_csr_pkg::remap_cnt_t remap_cnt;

  assign apb_acc = psel && penable;
  assign apb_wr  = apb_acc && pwrite;

  always_comb begin
    prdata  = '0;
    addr_ok = 1'b1;
    addr_ro = 1'b0;
    case (paddr)
      `PMEM_REG_CTRL: prdata[0] = enable_q;
      `PMEM_REG_STATUS: begin
        prdata[0] = init_done;  // ready bit.
        addr_ro   = 1'b1;
      end
      `PMEM_REG_REMAP_CNT: begin
        prdata  = pmem_csr_pkg::apb_data_t'(remap_cnt);
        addr_ro = 1'b1;
      end
      `PMEM_REG_MAP_QUERY: begin
        prdata[`PMEM_BIT_VBNK-1:0]              = q_vbank;
        prdata[`PMEM_BIT_VBNK +: `PMEM_BIT_VROW] = q_row;
      end
      `PMEM_REG_MAP_RESULT: begin
        prdata  = pmem_csr_pkg::apb_data_t'(q_pbank);
        addr_ro = 1'b1;
      end
      default: addr_ok = 1'b0;
    endcase
  end

  assign pready  = 1'b1;  // zero wait states.
  assign pslverr = apb_acc && (!addr_ok || (pwrite && addr_ro));

  always_ff @(posedge clk) begin
    if (rst_sync) begin
      enable_q <= 1'b1;  // the memory takes requests as soon as it is ready.
      q_row    <= '0;
      q_vbank  <= '0;
    end else if (apb_wr) begin
      if (paddr == `PMEM_REG_CTRL) begin
        enable_q <= pwdata[0];
      end
      if (paddr == `PMEM_REG_MAP_QUERY) begin
        q_vbank <= pwdata[`PMEM_BIT_VBNK-1:0];
        q_row   <= pwdata[`PMEM_BIT_VBNK +: `PMEM_BIT_VROW];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_sync) begin
      remap_cnt <= '0;
    end else if (remap_hit && (remap_cnt != '1)) begin
      remap_cnt <= remap_cnt + 1'b1;  // holds at all ones.
    end
  end

  assign accept_en = enable_q && init_done;  // the only place this gate is formed.

endmodule

// ==== pmem_csr_pkg.sv ====
package pmem_csr_pkg;

`include "pmem_cfg.svh"

  // byte address of the register block.
  typedef logic [`PMEM_APB_AW-1:0] apb_addr_t;

  // read and write data of the APB bus.
  typedef logic [31:0] apb_data_t;

  // count of writes that had to move to the pivot bank.
  typedef logic [15:0] remap_cnt_t;

endpackage

// ==== pmem_geom_pkg.sv ====
package pmem_geom_pkg;

`include "pmem_cfg.svh"

  // virtual address, vbank field in the low bits and row field above it.
  typedef logic [`PMEM_BIT_VADDR-1:0] vaddr_t;

  typedef logic [`PMEM_BIT_VBNK-1:0] vbank_t;  // virtual bank index.

  typedef logic [`PMEM_BIT_PBNK-1:0] pbank_t;  // physical bank index.

  typedef logic [`PMEM_BIT_VROW-1:0] row_t;  // row inside every bank.

  typedef logic [`PMEM_WIDTH-1:0] data_t;  // stored data word.

  // one map row, field i holds the physical bank of virtual bank i.
  // the top field holds the free pivot bank of the row.
  typedef pbank_t [`PMEM_NUM_PBNK-1:0] map_row_t;

endpackage

// ==== pmem_map_table.sv ====
`timescale 1ns/1ps

`include "pmem_cfg.svh"

module pmem_map_table (
  input  logic                    clk,
  input  logic                    rst_sync,
  input  pmem_geom_pkg::row_t     lk_rd_row,  // row of the read in the stage.
  input  pmem_geom_pkg::row_t     lk_wr_row,  // row of the write in the stage.
  input  logic                    upd_en,     // a redirected write swaps fields.
  input  pmem_geom_pkg::row_t     upd_row,
  input  pmem_geom_pkg::map_row_t upd_map,
  input  pmem_geom_pkg::row_t     q_row,      // query from the register block.
  input  pmem_geom_pkg::vbank_t   q_vbank,
  output pmem_geom_pkg::map_row_t lk_rd_map,
  output pmem_geom_pkg::map_row_t lk_wr_map,
  output pmem_geom_pkg::pbank_t   q_pbank,
  output logic                    init_done
);

  pmem_geom_pkg::map_row_t map_mem [`PMEM_NUM_VROW];  // one map row per data row.
  pmem_geom_pkg::map_row_t ident_row;  // field i holds bank i.
  pmem_geom_pkg::row_t     sweep_row;  // next row the init sweep writes.

  always_comb begin
    for (int i = 0; i < `PMEM_NUM_PBNK; i++) begin
      ident_row[i] = pmem_geom_pkg::pbank_t'(i);  // bank 4 starts as the pivot.
    end
  end

  // the sweep walks all rows once after reset, then stops for good.
  always_ff @(posedge clk) begin
    if (rst_sync) begin
      sweep_row <= '0;
      init_done <= 1'b0;
    end else if (!init_done) begin
      sweep_row <= sweep_row + 1'b1;
      if (sweep_row == `PMEM_NUM_VROW - 1) begin
        init_done <= 1'b1;  // the last row is written on this edge.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!init_done) begin
      map_mem[sweep_row] <= ident_row;  // identity while the sweep runs.
    end else if (upd_en) begin
      map_mem[upd_row] <= upd_map;  // swapped row lands with the bank write.
    end
  end

  // lookups see the flops directly, so an update is visible next cycle.
  assign lk_rd_map = map_mem[lk_rd_row];
  assign lk_wr_map = map_mem[lk_wr_row];

  assign q_pbank = map_mem[q_row][q_vbank];  // only virtual fields are queried.

endmodule

// ==== pmem_props.sv ====
`timescale 1ns/1ps

module pmem_props (
  input logic                  clk,
  input logic                  rst_sync,
  input logic                  rd_en,
  input pmem_geom_pkg::pbank_t rd_bank,
  input logic                  wr_en,
  input pmem_geom_pkg::pbank_t wr_bank,
  input logic                  vread_vld
);

  // each bank is single port, so the remap must keep the two apart.
  a_bank_apart: assert property (@(posedge clk) disable iff (rst_sync)
    !(rd_en && wr_en && (rd_bank == wr_bank)))
    else $error("read and write both hit bank %0d", rd_bank);

  a_vld_set: assert property (@(posedge clk) disable iff (rst_sync) rd_en |=> vread_vld)
    else $error("vread_vld missing one cycle after rd_en");

  a_vld_clr: assert property (@(posedge clk) disable iff (rst_sync) !rd_en |=> !vread_vld)
    else $error("vread_vld high without rd_en one cycle before");

  // the stage flops clear on the first reset edge.
  a_idle_reset: assert property (@(posedge clk) rst_sync |=> !(rd_en || wr_en))
    else $error("bank enable high while in reset");

endmodule

bind pmem_bank_array pmem_props u_props (
  .clk, .rst_sync, .rd_en, .rd_bank, .wr_en, .wr_bank, .vread_vld
);

// ==== pmem_remap_stage.sv ====
`timescale 1ns/1ps

`include "pmem_cfg.svh"

module pmem_remap_stage (
  input  logic                    clk,
  input  logic                    rst_sync,
  input  logic                    accept_en,    // enable and init done, from the CSR.
  input  logic                    vread,
  input  pmem_geom_pkg::vaddr_t   vread_addr,
  input  logic                    vwrite,
  input  pmem_geom_pkg::vaddr_t   vwrite_addr,
  input  pmem_geom_pkg::data_t    vwrite_data,
  input  pmem_geom_pkg::map_row_t lk_rd_map,    // map row of the read row.
  input  pmem_geom_pkg::map_row_t lk_wr_map,    // map row of the write row.
  output pmem_geom_pkg::row_t     lk_rd_row,
  output pmem_geom_pkg::row_t     lk_wr_row,
  output logic                    rd_en,
  output pmem_geom_pkg::pbank_t   rd_bank,
  output pmem_geom_pkg::row_t     rd_row,
  output logic                    wr_en,
  output pmem_geom_pkg::pbank_t   wr_bank,
  output pmem_geom_pkg::row_t     wr_row,
  output pmem_geom_pkg::data_t    wr_data,
  output logic                    upd_en,
  output pmem_geom_pkg::row_t     upd_row,
  output pmem_geom_pkg::map_row_t upd_map,
  output logic                    remap_hit     // one cycle per redirected write.
);

  logic                  rd_vld_q;     // a read is held in the stage.
  logic                  wr_vld_q;     // a write is held in the stage.
  pmem_geom_pkg::vaddr_t rd_addr_q;
  pmem_geom_pkg::vaddr_t wr_addr_q;
  pmem_geom_pkg::data_t  wr_data_q;
  pmem_geom_pkg::vbank_t rd_vbank;
  pmem_geom_pkg::vbank_t wr_vbank;
  pmem_geom_pkg::pbank_t rd_pbank;     // physical bank the read must use.
  pmem_geom_pkg::pbank_t wr_map_bank;  // bank the write would use without a clash.
  pmem_geom_pkg::pbank_t wr_pivot;     // free bank of the write row.
  logic                  bank_clash;

  always_ff @(posedge clk) begin
    if (rst_sync) begin
      rd_vld_q <= 1'b0;
      wr_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= vread & accept_en;  // requests outside accept_en are dropped.
      wr_vld_q <= vwrite & accept_en;
    end
  end

  always_ff @(posedge clk) begin
    if (vread && accept_en) begin
      rd_addr_q <= vread_addr;  // address only moves with a real request.
    end
    if (vwrite && accept_en) begin
      wr_addr_q <= vwrite_addr;
      wr_data_q <= vwrite_data;
    end
  end

  // low bits pick the virtual bank, the rest is the row.
  assign rd_vbank  = rd_addr_q[`PMEM_BIT_VBNK-1:0];
  assign wr_vbank  = wr_addr_q[`PMEM_BIT_VBNK-1:0];
  assign lk_rd_row = rd_addr_q[`PMEM_BIT_VADDR-1:`PMEM_BIT_VBNK];
  assign lk_wr_row = wr_addr_q[`PMEM_BIT_VADDR-1:`PMEM_BIT_VBNK];

  assign rd_pbank    = lk_rd_map[rd_vbank];
  assign wr_map_bank = lk_wr_map[wr_vbank];
  assign wr_pivot    = lk_wr_map[`PMEM_NUM_PBNK-1];

  // the pivot is never a mapped bank of its row, so it cannot clash again.
  assign bank_clash = rd_vld_q && wr_vld_q && (wr_map_bank == rd_pbank);

  always_comb begin
    upd_map                   = lk_wr_map;
    upd_map[wr_vbank]         = wr_pivot;     // the vbank now lives in the old pivot.
    upd_map[`PMEM_NUM_PBNK-1] = wr_map_bank;  // its stale copy becomes the pivot.
  end

  assign rd_en   = rd_vld_q;
  assign rd_bank = rd_pbank;
  assign rd_row  = lk_rd_row;

  assign wr_en   = wr_vld_q;
  assign wr_bank = bank_clash ? wr_pivot : wr_map_bank;
  assign wr_row  = lk_wr_row;
  assign wr_data = wr_data_q;

  assign upd_en    = bank_clash;  // an unchanged row is not written back.
  assign upd_row   = lk_wr_row;
  assign remap_hit = bank_clash;

endmodule

// ==== project.f ====
+incdir+.
pmem_geom_pkg.sv
pmem_csr_pkg.sv
pmem_map_table.sv
pmem_remap_stage.sv
pmem_bank_array.sv
pmem_csr.sv
pmem_core.sv
pmem_props.sv
tb_pmem.sv

// ==== tb_pmem.sv ====
`timescale 1ns/1ps

`include "pmem_cfg.svh"

module tb_pmem;

  logic                    clk = 1'b0;
  logic                    rst_sync;
  logic                    vread;
  pmem_geom_pkg::vaddr_t   vread_addr;
  logic                    vread_vld;
  pmem_geom_pkg::data_t    vdout;
  logic                    vwrite;
  pmem_geom_pkg::vaddr_t   vwrite_addr;
  pmem_geom_pkg::data_t    vwrite_data;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  pmem_csr_pkg::apb_addr_t paddr;
  pmem_csr_pkg::apb_data_t pwdata;
  pmem_csr_pkg::apb_data_t prdata;
  logic                    pready;
  logic                    pslverr;

  pmem_geom_pkg::map_row_t  model_map [`PMEM_NUM_VROW];  // reference map rows.
  pmem_geom_pkg::data_t     model_mem [`PMEM_NUM_PBNK][`PMEM_NUM_VROW];
  pmem_csr_pkg::remap_cnt_t model_cnt;      // expected REMAP_CNT.
  logic                     model_accept;   // enable bit as last written.
  pmem_geom_pkg::data_t     exp_q [$];      // expected vdout values in arrival order.
  int                       due_q [$];      // cycle in which each expected read must show.
  int                       cyc_cnt = 0;    // rising edges since time zero.
  int                       mismatch_cnt = 0;
  int                       other_cnt = 0;
  int                       reads_checked = 0;

  pmem_core uut (.*);

  always #2 clk = ~clk;  // 4 ns period.

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  task automatic check_data(input string name, input pmem_geom_pkg::data_t got,
                            input pmem_geom_pkg::data_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_pbank(input string name, input pmem_geom_pkg::pbank_t got,
                             input pmem_geom_pkg::pbank_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_apb(input string name, input pmem_csr_pkg::apb_data_t got,
                           input pmem_csr_pkg::apb_data_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("ERROR: timed out while %s at %0t", what, $time);
    $display("errors: %0d mismatches, %0d other, 1 timeout, %0d reads checked",
             mismatch_cnt, other_cnt, reads_checked);
    $display("TEST FAILED");
    $finish;
  endtask

  // models one memory cycle with the read ahead of the write, so a same cycle write is not seen.
  function automatic pmem_geom_pkg::data_t model_cycle(
    input logic rd, input pmem_geom_pkg::vaddr_t ra,
    input logic wr, input pmem_geom_pkg::vaddr_t wa, input pmem_geom_pkg::data_t wd);
    pmem_geom_pkg::row_t   rrow;
    pmem_geom_pkg::row_t   wrow;
    pmem_geom_pkg::pbank_t rbank;
    pmem_geom_pkg::pbank_t wbank;
    pmem_geom_pkg::pbank_t pivot;
    pmem_geom_pkg::data_t  rdata;
    rrow  = ra[`PMEM_BIT_VADDR-1:`PMEM_BIT_VBNK];
    wrow  = wa[`PMEM_BIT_VADDR-1:`PMEM_BIT_VBNK];
    rbank = model_map[rrow][ra[`PMEM_BIT_VBNK-1:0]];
    rdata = model_mem[rbank][rrow];
    if (wr) begin
      wbank = model_map[wrow][wa[`PMEM_BIT_VBNK-1:0]];
      if (rd && (wbank == rbank)) begin
        pivot = model_map[wrow][`PMEM_NUM_PBNK-1];  // the read holds this bank, so the write moves.
        model_map[wrow][wa[`PMEM_BIT_VBNK-1:0]] = pivot;
        model_map[wrow][`PMEM_NUM_PBNK-1] = wbank;
        wbank = pivot;
        if (model_cnt != '1) begin
          model_cnt++;
        end
      end
      model_mem[wbank][wrow] = wd;
    end
    return rdata;
  endfunction

  // drive one cycle of both ports and predict the read.
  task automatic drive_cycle(input logic rd, input pmem_geom_pkg::vaddr_t ra, input logic wr,
                             input pmem_geom_pkg::vaddr_t wa, input pmem_geom_pkg::data_t wd);
    pmem_geom_pkg::data_t exp_rd;
    vread       = rd;
    vread_addr  = ra;
    vwrite      = wr;
    vwrite_addr = wa;
    vwrite_data = wd;
    if (model_accept) begin
      exp_rd = model_cycle(rd, ra, wr, wa, wd);
      if (rd) begin
        exp_q.push_back(exp_rd);
        due_q.push_back(cyc_cnt + 2);  // sampled next edge, data out one edge later.
      end
    end
    @(posedge clk);
    #0.5;
    vread  = 1'b0;
    vwrite = 1'b0;
  endtask

  task automatic drain_reads();
    int waits;
    waits = 0;
    while (exp_q.size() != 0) begin
      if (waits == 20) begin
        stop_on_timeout("waiting for read data");
      end
      waits++;
      @(posedge clk);
      #0.5;
    end
  endtask

  // drives the setup phase and then holds the access phase until pready.
  task automatic apb_xfer(input logic wr, input pmem_csr_pkg::apb_addr_t addr,
                          input pmem_csr_pkg::apb_data_t wdata,
                          output pmem_csr_pkg::apb_data_t rdata, output logic err);
    int waits;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #0.5;
    penable = 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready) begin
      if (waits == 10) begin
        stop_on_timeout("waiting for pready");
      end
      waits++;
      @(negedge clk);
    end
    rdata = prdata;  // prdata has settled by mid cycle.
    err   = pslverr;
    @(posedge clk);
    #0.5;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input pmem_csr_pkg::apb_addr_t addr,
                           input pmem_csr_pkg::apb_data_t wdata);
    pmem_csr_pkg::apb_data_t rdata;
    logic                    err;
    apb_xfer(1'b1, addr, wdata, rdata, err);
    if (err !== 1'b0) begin
      other_cnt++;
      $display("ERROR: pslverr on write to offset 0x%h", addr);
    end
  endtask

  task automatic read_reg(input pmem_csr_pkg::apb_addr_t addr,
                          output pmem_csr_pkg::apb_data_t rdata);
    logic err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    if (err !== 1'b0) begin
      other_cnt++;
      $display("ERROR: pslverr on read of offset 0x%h", addr);
    end
  endtask

  task automatic query_map(input pmem_geom_pkg::row_t row, input pmem_geom_pkg::vbank_t vb);
    pmem_csr_pkg::apb_data_t rdata;
    write_reg(`PMEM_REG_MAP_QUERY, pmem_csr_pkg::apb_data_t'({row, vb}));
    read_reg(`PMEM_REG_MAP_RESULT, rdata);
    check_pbank("MAP_RESULT", pmem_geom_pkg::pbank_t'(rdata), model_map[row][vb]);
  endtask

  task automatic check_remap_cnt();
    pmem_csr_pkg::apb_data_t rdata;
    read_reg(`PMEM_REG_REMAP_CNT, rdata);
    check_apb("REMAP_CNT", rdata, pmem_csr_pkg::apb_data_t'(model_cnt));
  endtask

  task automatic wait_ready();
    pmem_csr_pkg::apb_data_t rdata;
    int                      polls;
    read_reg(`PMEM_REG_STATUS, rdata);
    check_apb("STATUS", rdata, 32'h0);  // the sweep still runs here.
    polls = 0;
    while (rdata !== 32'h1) begin
      if (polls == 30) begin
        stop_on_timeout("polling STATUS for ready");
      end
      polls++;
      read_reg(`PMEM_REG_STATUS, rdata);
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < 64; i++) begin
      drive_cycle(1'b1, pmem_geom_pkg::vaddr_t'(i), 1'b0, '0, '0);
    end
    drain_reads();
  endtask

  // every vread_vld must meet a predicted read in the cycle it is due.
  always @(negedge clk) begin
    if (!rst_sync && vread_vld) begin
      if (exp_q.size() == 0) begin
        other_cnt++;
        $display("ERROR: vread_vld high with no read outstanding at %0t", $time);
      end else begin
        if (due_q[0] != cyc_cnt) begin
          other_cnt++;
          $display("ERROR: read data came in cycle %0d but was due in cycle %0d",
                   cyc_cnt, due_q[0]);
        end
        check_data("vdout", vdout, exp_q.pop_front());
        void'(due_q.pop_front());
        reads_checked++;
      end
    end else if ((due_q.size() != 0) && (due_q[0] == cyc_cnt)) begin
      other_cnt++;
      $display("ERROR: vread_vld low in cycle %0d where read data was due", cyc_cnt);
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end
  end

  initial begin
    pmem_csr_pkg::apb_data_t rdata;
    logic                    err;
    pmem_geom_pkg::vaddr_t   addr;
    void'($urandom(32'h1fec));
    rst_sync    = 1'b1;
    vread       = 1'b0;
    vread_addr  = '0;
    vwrite      = 1'b0;
    vwrite_addr = '0;
    vwrite_data = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    for (int r = 0; r < `PMEM_NUM_VROW; r++) begin
      for (int f = 0; f < `PMEM_NUM_PBNK; f++) begin
        model_map[r][f] = pmem_geom_pkg::pbank_t'(f);  // identity after the sweep.
      end
    end
    model_cnt    = '0;
    model_accept = 1'b1;
    repeat (8) @(posedge clk);
    #0.5;
    rst_sync = 1'b0;

    wait_ready();
    for (int i = 0; i < 8; i++) begin
      query_map(pmem_geom_pkg::row_t'($urandom), pmem_geom_pkg::vbank_t'($urandom));
    end

    for (int i = 0; i < 64; i++) begin
      drive_cycle(1'b0, '0, 1'b1, pmem_geom_pkg::vaddr_t'(i), pmem_geom_pkg::data_t'($urandom));
    end
    read_all();
    check_remap_cnt();

    addr = 6'h1A;  // row 6 vbank 2 is read and written in the same cycle.
    drive_cycle(1'b1, addr, 1'b1, addr, 16'hC3A5);
    drive_cycle(1'b1, addr, 1'b0, '0, '0);
    drain_reads();
    check_remap_cnt();
    query_map(addr[5:2], addr[1:0]);

    for (int i = 0; i < 400; i++) begin
      drive_cycle(1'b1, pmem_geom_pkg::vaddr_t'($urandom), 1'b1,
                  pmem_geom_pkg::vaddr_t'($urandom), pmem_geom_pkg::data_t'($urandom));
    end
    drain_reads();
    check_remap_cnt();
    for (int r = 0; r < `PMEM_NUM_VROW; r++) begin
      for (int v = 0; v < `PMEM_NUM_VBNK; v++) begin
        query_map(pmem_geom_pkg::row_t'(r), pmem_geom_pkg::vbank_t'(v));
      end
    end
    read_all();

    write_reg(`PMEM_REG_CTRL, 32'h0);
    model_accept = 1'b0;
    read_reg(`PMEM_REG_CTRL, rdata);
    check_apb("CTRL", rdata, 32'h0);
    for (int i = 0; i < 20; i++) begin
      drive_cycle(1'b1, pmem_geom_pkg::vaddr_t'($urandom), 1'b1,
                  pmem_geom_pkg::vaddr_t'($urandom), pmem_geom_pkg::data_t'($urandom));
    end
    repeat (4) @(posedge clk);  // quiet time for a stray vread_vld.
    #0.5;
    apb_xfer(1'b0, 5'h14, '0, rdata, err);
    if (err !== 1'b1) begin
      other_cnt++;
      $display("ERROR: no pslverr on a read of unlisted offset 0x14");
    end
    apb_xfer(1'b1, `PMEM_REG_STATUS, 32'h1, rdata, err);
    if (err !== 1'b1) begin
      other_cnt++;
      $display("ERROR: no pslverr on a write to read-only STATUS");
    end
    write_reg(`PMEM_REG_CTRL, 32'h1);
    model_accept = 1'b1;
    read_all();
    check_remap_cnt();

    $display("errors: %0d mismatches, %0d other, %0d reads checked",
             mismatch_cnt, other_cnt, reads_checked);
    if ((mismatch_cnt == 0) && (other_cnt == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
